//--- verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width of the core
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NREGS 32

`define RV_RESET_ADDR 32'h0000_0000  // first word fetched after reset

`define RV_EBREAK 32'h0010_0073  // retiring this word ends a program
`define RV_NOP    32'h0000_0013  // addi x0, x0, 0 fills empty pipeline slots

`endif

//--- verilog/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;  // one datum or one byte address
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

  // major opcodes kept by this subset, anything else decodes as a bubble
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,  // signed compare
    alu_sll,
    alu_srl
  } alu_op_e;

  // source of the value written to rd
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc4
  } wb_sel_e;

endpackage

//--- verilog/rv_fetch.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_fetch (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_stall,
  input  logic          i_taken,
  input  rv_pkg::word_t i_target,
  input  rv_pkg::word_t i_imem_rdata,
  output rv_pkg::word_t o_imem_raddr,
  output rv_pkg::word_t o_if_pc,
  output rv_pkg::word_t o_if_inst,
  output logic          o_if_valid
);
  import rv_pkg::*;

  // the instruction memory output acts as the word half of IF/ID
  // pc_q and valid_q are its address and valid halves
  word_t pc_q;
  word_t next_pc;
  logic  valid_q;  // low while the word on i_imem_rdata is not a real fetch

  // a stall or an empty slot presents the same address again
  always_comb begin
    if (i_taken) begin
      next_pc = i_target;
    end else if (i_stall || !valid_q) begin
      next_pc = pc_q;
    end else begin
      next_pc = pc_q + 4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q    <= `RV_RESET_ADDR;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= next_pc;
      valid_q <= !i_taken;  // the slot behind a redirect is flushed
    end
  end

  assign o_imem_raddr = next_pc;  // memory returns this word after the edge
  assign o_if_pc      = pc_q;
  assign o_if_inst    = valid_q ? i_imem_rdata : `RV_NOP;
  assign o_if_valid   = valid_q;

endmodule

//--- verilog/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_stall,
  input  logic              i_flush,
  input  logic              i_if_valid,
  input  rv_pkg::word_t     i_if_pc,
  input  rv_pkg::word_t     i_if_inst,
  input  rv_pkg::word_t     i_rs1_rdata,
  input  rv_pkg::word_t     i_rs2_rdata,
  output rv_pkg::reg_addr_t o_rs1_raddr,
  output rv_pkg::reg_addr_t o_rs2_raddr,
  output logic              o_ex_valid,
  output logic              o_ex_mem_read,
  output logic              o_ex_mem_write,
  output logic              o_ex_reg_write,
  output logic              o_ex_branch,
  output logic              o_ex_bne,
  output logic              o_ex_jal,
  output logic              o_ex_use_imm,
  output rv_pkg::alu_op_e   o_ex_alu_op,
  output rv_pkg::wb_sel_e   o_ex_wb_sel,
  output rv_pkg::word_t     o_ex_pc,
  output rv_pkg::word_t     o_ex_imm,
  output rv_pkg::word_t     o_ex_rs1_data,
  output rv_pkg::word_t     o_ex_rs2_data,
  output rv_pkg::word_t     o_ex_inst
);
  import rv_pkg::*;

  opcode_e   opcode;
  logic [2:0] funct3;
  reg_addr_t rd;
  word_t     imm_i, imm_s, imm_b, imm_j, imm_u;
  logic      mem_read, mem_write, reg_write, branch, jal, use_imm;
  logic      rs1_used, rs2_used;
  alu_op_e   alu_op;
  alu_op_e   funct_op;  // operation named by funct3 and funct7
  wb_sel_e   wb_sel;
  word_t     imm;
  logic      live;  // this slot carries an instruction into execute

  assign opcode = opcode_e'(i_if_inst[6:0]);
  assign funct3 = i_if_inst[14:12];
  assign rd     = i_if_inst[11:7];

  assign imm_i = {{20{i_if_inst[31]}}, i_if_inst[31:20]};
  assign imm_s = {{20{i_if_inst[31]}}, i_if_inst[31:25], i_if_inst[11:7]};
  assign imm_b = {{19{i_if_inst[31]}}, i_if_inst[31], i_if_inst[7], i_if_inst[30:25],
                  i_if_inst[11:8], 1'b0};
  assign imm_j = {{11{i_if_inst[31]}}, i_if_inst[31], i_if_inst[19:12], i_if_inst[20],
                  i_if_inst[30:21], 1'b0};
  assign imm_u = {i_if_inst[31:12], 12'h000};

  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == op_reg && i_if_inst[30]) ? alu_sub : alu_add;
      3'b001:  funct_op = alu_sll;
      3'b010:  funct_op = alu_slt;
      3'b100:  funct_op = alu_xor;
      3'b101:  funct_op = alu_srl;
      3'b110:  funct_op = alu_or;
      3'b111:  funct_op = alu_and;
      default: funct_op = alu_add;  // sltu is not in the subset
    endcase
  end

  always_comb begin
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    use_imm   = 1'b0;
    rs1_used  = 1'b0;
    rs2_used  = 1'b0;
    alu_op    = alu_add;  // address and lui arithmetic are plain adds
    wb_sel    = wb_alu;
    imm       = imm_i;
    case (opcode)
      op_reg: begin
        {reg_write, rs1_used, rs2_used} = 3'b111;
        alu_op = funct_op;
      end
      op_imm: begin
        {reg_write, rs1_used, use_imm} = 3'b111;
        alu_op = funct_op;
      end
      op_lui: begin
        {reg_write, use_imm} = 2'b11;  // rs1 stays x0 so the add passes imm through
        imm = imm_u;
      end
      op_load: begin
        {mem_read, reg_write, rs1_used, use_imm} = 4'b1111;
        wb_sel = wb_mem;
      end
      op_store: begin
        {mem_write, rs1_used, rs2_used, use_imm} = 4'b1111;
        imm = imm_s;
      end
      op_branch: begin
        branch   = (funct3[2:1] == 2'b00);  // beq and bne only
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        imm      = imm_b;
      end
      op_jal: begin
        {jal, reg_write} = 2'b11;
        wb_sel = wb_pc4;
        imm    = imm_j;
      end
      default: begin
        // ebreak and unknown words move through with no side effects
      end
    endcase
  end

  // unused source fields read x0 and never trigger a stall
  assign o_rs1_raddr = rs1_used ? i_if_inst[19:15] : '0;
  assign o_rs2_raddr = rs2_used ? i_if_inst[24:20] : '0;

  assign live = i_if_valid && !i_stall && !i_flush;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ex_valid     <= 1'b0;
      o_ex_mem_read  <= 1'b0;
      o_ex_mem_write <= 1'b0;
      o_ex_reg_write <= 1'b0;
      o_ex_branch    <= 1'b0;
      o_ex_jal       <= 1'b0;
    end else begin
      o_ex_valid     <= live;
      o_ex_mem_read  <= live && mem_read;
      o_ex_mem_write <= live && mem_write;
      o_ex_reg_write <= live && reg_write && (rd != '0);  // x0 writes vanish here
      o_ex_branch    <= live && branch;
      o_ex_jal       <= live && jal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_bne      <= funct3[0];
    o_ex_use_imm  <= use_imm;
    o_ex_alu_op   <= alu_op;
    o_ex_wb_sel   <= wb_sel;
    o_ex_pc       <= i_if_pc;
    o_ex_imm      <= imm;
    o_ex_rs1_data <= i_rs1_rdata;
    o_ex_rs2_data <= i_rs2_rdata;
    o_ex_inst     <= i_if_inst;  // rd travels in bits 11:7
  end

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_regfile (
  input  logic              i_clk,
  input  logic              i_rst,
  input  rv_pkg::reg_addr_t i_rs1_raddr,
  input  rv_pkg::reg_addr_t i_rs2_raddr,
  input  rv_pkg::reg_addr_t i_rd_waddr,
  input  logic              i_rd_wen,
  input  rv_pkg::word_t     i_rd_wdata,
  output rv_pkg::word_t     o_rs1_rdata,
  output rv_pkg::word_t     o_rs2_rdata
);
  import rv_pkg::*;

  word_t regs [`RV_NREGS];  // entry zero is never written
  logic  wr;

  assign wr = i_rd_wen && !i_rst && (i_rd_waddr != '0);

  always_ff @(posedge i_clk) begin
    if (wr) regs[i_rd_waddr] <= i_rd_wdata;
  end

  // writeback and decode meet in the same cycle, so the new value wins
  assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 :
                       (wr && i_rs1_raddr == i_rd_waddr) ? i_rd_wdata : regs[i_rs1_raddr];
  assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 :
                       (wr && i_rs2_raddr == i_rd_waddr) ? i_rd_wdata : regs[i_rs2_raddr];

endmodule

//--- verilog/rv_hazard.sv
`timescale 1ns/10ps

module rv_hazard (
  input  rv_pkg::reg_addr_t i_id_rs1,
  input  rv_pkg::reg_addr_t i_id_rs2,
  input  rv_pkg::reg_addr_t i_ex_rs1,
  input  rv_pkg::reg_addr_t i_ex_rs2,
  input  rv_pkg::reg_addr_t i_ex_rd,
  input  rv_pkg::reg_addr_t i_mem_rd,
  input  rv_pkg::reg_addr_t i_wb_rd,
  input  logic              i_ex_mem_read,
  input  logic              i_mem_reg_write,
  input  logic              i_wb_reg_write,
  output logic              o_stall,
  output logic [1:0]        o_fwd_a,
  output logic [1:0]        o_fwd_b
);
  import rv_pkg::*;

  // select codes 00 register file, 01 memory stage, 10 writeback stage
  function automatic logic [1:0] fwd_sel(
    input reg_addr_t rs,
    input reg_addr_t mem_rd,
    input logic      mem_we,
    input reg_addr_t wb_rd,
    input logic      wb_we
  );
    if (mem_we && rs == mem_rd) begin
      return 2'b01;  // the younger producer holds the newer value
    end else if (wb_we && rs == wb_rd) begin
      return 2'b10;
    end
    return 2'b00;
  endfunction

  // register write enables are never set for x0, so rd is nonzero when they are
  assign o_fwd_a = fwd_sel(i_ex_rs1, i_mem_rd, i_mem_reg_write, i_wb_rd, i_wb_reg_write);
  assign o_fwd_b = fwd_sel(i_ex_rs2, i_mem_rd, i_mem_reg_write, i_wb_rd, i_wb_reg_write);

  // load data is only ready in writeback, one cycle too late for the next op
  assign o_stall = i_ex_mem_read && (i_ex_rd != '0) &&
                   ((i_ex_rd == i_id_rs1) || (i_ex_rd == i_id_rs2));

endmodule

//--- verilog/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_ex_valid,
  input  logic              i_ex_mem_read,
  input  logic              i_ex_mem_write,
  input  logic              i_ex_reg_write,
  input  logic              i_ex_branch,
  input  logic              i_ex_bne,
  input  logic              i_ex_jal,
  input  logic              i_ex_use_imm,
  input  rv_pkg::alu_op_e   i_ex_alu_op,
  input  rv_pkg::wb_sel_e   i_ex_wb_sel,
  input  rv_pkg::word_t     i_ex_pc,
  input  rv_pkg::word_t     i_ex_imm,
  input  rv_pkg::word_t     i_ex_rs1_data,
  input  rv_pkg::word_t     i_ex_rs2_data,
  input  rv_pkg::word_t     i_ex_inst,
  input  logic [1:0]        i_fwd_a,
  input  logic [1:0]        i_fwd_b,
  input  rv_pkg::word_t     i_mem_fwd_data,
  input  rv_pkg::word_t     i_wb_fwd_data,
  output logic              o_taken,
  output rv_pkg::word_t     o_target,
  output rv_pkg::reg_addr_t o_mem_rd,
  output logic              o_mem_reg_write,
  output logic              o_mem_valid,
  output rv_pkg::wb_sel_e   o_mem_wb_sel,
  output rv_pkg::word_t     o_mem_result,
  output rv_pkg::word_t     o_mem_pc,
  output rv_pkg::word_t     o_mem_inst,
  output rv_pkg::word_t     o_dmem_addr,
  output rv_pkg::word_t     o_dmem_wdata,
  output logic              o_dmem_ren,
  output logic              o_dmem_wen
);
  import rv_pkg::*;

  word_t fwd_a;
  word_t fwd_b;  // also the store data
  word_t op_a;
  word_t op_b;
  word_t alu_y;

  function automatic word_t fwd_mux(input logic [1:0] sel, input word_t rf,
                                    input word_t mem, input word_t wb);
    case (sel)
      2'b01:   return mem;
      2'b10:   return wb;
      default: return rf;
    endcase
  endfunction

  assign fwd_a = fwd_mux(i_fwd_a, i_ex_rs1_data, i_mem_fwd_data, i_wb_fwd_data);
  assign fwd_b = fwd_mux(i_fwd_b, i_ex_rs2_data, i_mem_fwd_data, i_wb_fwd_data);

  // the rs1 field of lui is immediate bits and must not pick up a forward
  assign op_a = (opcode_e'(i_ex_inst[6:0]) == op_lui) ? '0 : fwd_a;
  assign op_b = i_ex_use_imm ? i_ex_imm : fwd_b;

  always_comb begin
    case (i_ex_alu_op)
      alu_sub: alu_y = op_a - op_b;
      alu_and: alu_y = op_a & op_b;
      alu_or:  alu_y = op_a | op_b;
      alu_xor: alu_y = op_a ^ op_b;
      alu_slt: alu_y = word_t'($signed(op_a) < $signed(op_b));
      alu_sll: alu_y = op_a << op_b[4:0];
      alu_srl: alu_y = op_a >> op_b[4:0];
      default: alu_y = op_a + op_b;
    endcase
  end

  // bne inverts the equality test of beq
  assign o_taken  = i_ex_jal || (i_ex_branch && ((fwd_a == fwd_b) != i_ex_bne));
  assign o_target = i_ex_pc + i_ex_imm;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_valid     <= 1'b0;
      o_mem_reg_write <= 1'b0;
      o_dmem_ren      <= 1'b0;
      o_dmem_wen      <= 1'b0;
    end else begin
      o_mem_valid     <= i_ex_valid;
      o_mem_reg_write <= i_ex_reg_write;
      o_dmem_ren      <= i_ex_mem_read;
      o_dmem_wen      <= i_ex_mem_write;
    end
  end

  always_ff @(posedge i_clk) begin
    o_mem_wb_sel <= i_ex_wb_sel;
    o_mem_result <= alu_y;  // doubles as the data address
    o_mem_pc     <= i_ex_pc;
    o_mem_inst   <= i_ex_inst;
    o_dmem_wdata <= fwd_b;
  end

  assign o_dmem_addr = o_mem_result;
  assign o_mem_rd    = o_mem_inst[11:7];

endmodule

//--- verilog/rv_writeback.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_writeback (
  input  logic              i_clk,
  input  logic              i_rst,
  input  rv_pkg::reg_addr_t i_mem_rd,
  input  logic              i_mem_reg_write,
  input  logic              i_mem_valid,
  input  rv_pkg::wb_sel_e   i_mem_wb_sel,
  input  rv_pkg::word_t     i_mem_result,
  input  rv_pkg::word_t     i_mem_pc,
  input  rv_pkg::word_t     i_mem_inst,
  input  rv_pkg::word_t     i_dmem_rdata,
  output rv_pkg::reg_addr_t o_wb_rd,
  output logic              o_wb_reg_write,
  output rv_pkg::word_t     o_wb_data,
  output logic              o_retire_valid,
  output logic              o_retire_halt,
  output rv_pkg::word_t     o_retire_inst,
  output rv_pkg::word_t     o_retire_pc,
  output rv_pkg::reg_addr_t o_retire_rd_waddr,
  output rv_pkg::word_t     o_retire_rd_wdata
);
  import rv_pkg::*;

  logic      valid_q;
  logic      reg_write_q;
  reg_addr_t rd_q;
  wb_sel_e   sel_q;
  word_t     result_q;
  word_t     pc_q;
  word_t     inst_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
    end else begin
      valid_q     <= i_mem_valid;
      reg_write_q <= i_mem_reg_write;
    end
  end

  always_ff @(posedge i_clk) begin
    rd_q     <= i_mem_rd;
    sel_q    <= i_mem_wb_sel;
    result_q <= i_mem_result;
    pc_q     <= i_mem_pc;
    inst_q   <= i_mem_inst;
  end

  // load data arrives straight from memory in this cycle
  always_comb begin
    case (sel_q)
      wb_mem:  o_wb_data = i_dmem_rdata;
      wb_pc4:  o_wb_data = pc_q + 4;  // jal link value
      default: o_wb_data = result_q;
    endcase
  end

  assign o_wb_rd        = rd_q;
  assign o_wb_reg_write = reg_write_q;

  assign o_retire_valid    = valid_q;
  assign o_retire_halt     = valid_q && (inst_q == `RV_EBREAK);
  assign o_retire_inst     = inst_q;
  assign o_retire_pc       = pc_q;
  assign o_retire_rd_waddr = reg_write_q ? rd_q : '0;  // stores and branches report x0
  assign o_retire_rd_wdata = o_wb_data;

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic              i_clk,
  input  logic              i_rst,
  output rv_pkg::word_t     o_imem_raddr,
  input  rv_pkg::word_t     i_imem_rdata,
  output rv_pkg::word_t     o_dmem_addr,
  output rv_pkg::word_t     o_dmem_wdata,
  output logic              o_dmem_ren,
  output logic              o_dmem_wen,
  input  rv_pkg::word_t     i_dmem_rdata,
  output logic              o_retire_valid,
  output logic              o_retire_halt,
  output rv_pkg::word_t     o_retire_inst,
  output rv_pkg::word_t     o_retire_pc,
  output rv_pkg::word_t     o_retire_rd_wdata,
  output rv_pkg::reg_addr_t o_retire_rd_waddr
);
  import rv_pkg::*;

  // hazard and redirect
  logic      stall;
  logic      taken;
  word_t     target;
  logic [1:0] fwd_a;
  logic [1:0] fwd_b;

  // fetch to decode
  word_t     if_pc;
  word_t     if_inst;
  logic      if_valid;

  reg_addr_t rs1_raddr;
  reg_addr_t rs2_raddr;
  word_t     rs1_rdata;
  word_t     rs2_rdata;

  // ID/EX
  logic      ex_valid, ex_mem_read, ex_mem_write, ex_reg_write;
  logic      ex_branch, ex_bne, ex_jal, ex_use_imm;
  alu_op_e   ex_alu_op;
  wb_sel_e   ex_wb_sel;
  word_t     ex_pc, ex_imm, ex_rs1_data, ex_rs2_data, ex_inst;

  // EX/MEM
  reg_addr_t mem_rd;
  logic      mem_reg_write;
  logic      mem_valid;
  wb_sel_e   mem_wb_sel;
  word_t     mem_result, mem_pc, mem_inst;

  // MEM/WB register write port, also the oldest forwarding source
  reg_addr_t wb_rd;
  logic      wb_reg_write;
  word_t     wb_data;

  rv_fetch fetch_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (stall),
    .i_taken      (taken),
    .i_target     (target),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_if_pc      (if_pc),
    .o_if_inst    (if_inst),
    .o_if_valid   (if_valid)
  );

  rv_decode decode_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_stall        (stall),
    .i_flush        (taken),  // the word in decode is on the wrong path
    .i_if_valid     (if_valid),
    .i_if_pc        (if_pc),
    .i_if_inst      (if_inst),
    .i_rs1_rdata    (rs1_rdata),
    .i_rs2_rdata    (rs2_rdata),
    .o_rs1_raddr    (rs1_raddr),
    .o_rs2_raddr    (rs2_raddr),
    .o_ex_valid     (ex_valid),
    .o_ex_mem_read  (ex_mem_read),
    .o_ex_mem_write (ex_mem_write),
    .o_ex_reg_write (ex_reg_write),
    .o_ex_branch    (ex_branch),
    .o_ex_bne       (ex_bne),
    .o_ex_jal       (ex_jal),
    .o_ex_use_imm   (ex_use_imm),
    .o_ex_alu_op    (ex_alu_op),
    .o_ex_wb_sel    (ex_wb_sel),
    .o_ex_pc        (ex_pc),
    .o_ex_imm       (ex_imm),
    .o_ex_rs1_data  (ex_rs1_data),
    .o_ex_rs2_data  (ex_rs2_data),
    .o_ex_inst      (ex_inst)
  );

  rv_regfile regfile_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (rs2_raddr),
    .i_rd_waddr  (wb_rd),
    .i_rd_wen    (wb_reg_write),
    .i_rd_wdata  (wb_data),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata)
  );

  rv_hazard hazard_i (
    .i_id_rs1        (rs1_raddr),
    .i_id_rs2        (rs2_raddr),
    .i_ex_rs1        (ex_inst[19:15]),
    .i_ex_rs2        (ex_inst[24:20]),
    .i_ex_rd         (ex_inst[11:7]),
    .i_mem_rd        (mem_rd),
    .i_wb_rd         (wb_rd),
    .i_ex_mem_read   (ex_mem_read),
    .i_mem_reg_write (mem_reg_write),
    .i_wb_reg_write  (wb_reg_write),
    .o_stall         (stall),
    .o_fwd_a         (fwd_a),
    .o_fwd_b         (fwd_b)
  );

  rv_execute execute_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_ex_valid      (ex_valid),
    .i_ex_mem_read   (ex_mem_read),
    .i_ex_mem_write  (ex_mem_write),
    .i_ex_reg_write  (ex_reg_write),
    .i_ex_branch     (ex_branch),
    .i_ex_bne        (ex_bne),
    .i_ex_jal        (ex_jal),
    .i_ex_use_imm    (ex_use_imm),
    .i_ex_alu_op     (ex_alu_op),
    .i_ex_wb_sel     (ex_wb_sel),
    .i_ex_pc         (ex_pc),
    .i_ex_imm        (ex_imm),
    .i_ex_rs1_data   (ex_rs1_data),
    .i_ex_rs2_data   (ex_rs2_data),
    .i_ex_inst       (ex_inst),
    .i_fwd_a         (fwd_a),
    .i_fwd_b         (fwd_b),
    .i_mem_fwd_data  (mem_result),
    .i_wb_fwd_data   (wb_data),
    .o_taken         (taken),
    .o_target        (target),
    .o_mem_rd        (mem_rd),
    .o_mem_reg_write (mem_reg_write),
    .o_mem_valid     (mem_valid),
    .o_mem_wb_sel    (mem_wb_sel),
    .o_mem_result    (mem_result),
    .o_mem_pc        (mem_pc),
    .o_mem_inst      (mem_inst),
    .o_dmem_addr     (o_dmem_addr),
    .o_dmem_wdata    (o_dmem_wdata),
    .o_dmem_ren      (o_dmem_ren),
    .o_dmem_wen      (o_dmem_wen)
  );

  rv_writeback writeback_i (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_mem_rd          (mem_rd),
    .i_mem_reg_write   (mem_reg_write),
    .i_mem_valid       (mem_valid),
    .i_mem_wb_sel      (mem_wb_sel),
    .i_mem_result      (mem_result),
    .i_mem_pc          (mem_pc),
    .i_mem_inst        (mem_inst),
    .i_dmem_rdata      (i_dmem_rdata),
    .o_wb_rd           (wb_rd),
    .o_wb_reg_write    (wb_reg_write),
    .o_wb_data         (wb_data),
    .o_retire_valid    (o_retire_valid),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_rd_waddr (o_retire_rd_waddr),
    .o_retire_rd_wdata (o_retire_rd_wdata)
  );

endmodule

//--- test/rv_tb_clock.sv
`timescale 1ns/10ps

module rv_tb_clock (
  output logic o_clk,
  output logic o_rst
);

  // 100 ns period, first rising edge at 50 ns
  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;  // held through the first 16 rising edges
    repeat (16) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;  // released half a cycle away from the sampling edge
  end

endmodule

//--- test/rv_core_sva.sv
`timescale 1ns/10ps

module rv_core_sva (
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_dmem_ren,
  input logic              i_dmem_wen,
  input logic              i_retire_valid,
  input logic              i_retire_halt,
  input rv_pkg::word_t     i_retire_inst,
  input rv_pkg::reg_addr_t i_retire_rd_waddr
);
  import rv_pkg::*;

  int unsigned fails = 0;  // number of failed properties so far
  logic        writes_rd;  // the retiring opcode has a destination register

  assign writes_rd = i_retire_inst[6:0] inside {op_reg, op_imm, op_lui, op_load, op_jal};

  // a data memory cycle is a read or a write, never both
  one_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem_ren && i_dmem_wen))
    else begin
      $error("data memory read and write strobes are high together");
      fails++;
    end

  // a register writer reports the rd field of its own word
  rd_from_inst: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_retire_valid && writes_rd && i_retire_inst[11:7] != '0) |->
      i_retire_rd_waddr == i_retire_inst[11:7])
    else begin
      $error("a register write retired without its rd address");
      fails++;
    end

  // stores, branches, ebreak and writes to x0 all report x0
  x0_silent: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_retire_valid && (!writes_rd || i_retire_inst[11:7] == '0)) |->
      i_retire_rd_waddr == '0)
    else begin
      $error("a write to x0 or a non-writing word was reported with a nonzero rd address");
      fails++;
    end

  // the first reset edge clears MEM/WB, so from then on nothing retires
  reset_quiet: assert property (@(posedge i_clk)
    (i_rst && $past(i_rst)) |-> (!i_retire_valid && !i_retire_halt))
    else begin
      $error("retire outputs active while reset is held");
      fails++;
    end

endmodule

bind rv_core rv_core_sva sva_i (
  .i_clk             (i_clk),
  .i_rst             (i_rst),
  .i_dmem_ren        (o_dmem_ren),
  .i_dmem_wen        (o_dmem_wen),
  .i_retire_valid    (o_retire_valid),
  .i_retire_halt     (o_retire_halt),
  .i_retire_inst     (o_retire_inst),
  .i_retire_rd_waddr (o_retire_rd_waddr)
);

//--- test/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_core_tb;
  import rv_pkg::*;

  logic      clk;
  logic      rst;
  word_t     imem_raddr;
  word_t     imem_rdata;
  word_t     dmem_addr;
  word_t     dmem_wdata;
  logic      dmem_ren;
  logic      dmem_wen;
  word_t     dmem_rdata;
  logic      retire_valid;
  logic      retire_halt;
  word_t     retire_inst;
  word_t     retire_pc;
  word_t     retire_rd_wdata;
  reg_addr_t retire_rd_waddr;

  word_t     imem [64];   // program words, indexed by pc bits 7:2
  word_t     dmem [256];
  word_t     imem_addr_q; // address registers of the two synchronous memories
  word_t     dmem_addr_q;

  // expectation table in retire order, one entry per retiring instruction
  word_t     exp_pc [$];
  reg_addr_t exp_rd [$];
  word_t     exp_data [$];
  word_t     x [32];      // register values that the program should produce
  word_t     pc_next;     // where the next table entry is placed
  word_t     st_addr;
  word_t     st_data;
  int        stores;
  integer    seed;

  rv_tb_clock clock_i (
    .o_clk (clk),
    .o_rst (rst)
  );

  rv_core rv_core_i (
    .i_clk             (clk),
    .i_rst             (rst),
    .o_imem_raddr      (imem_raddr),
    .i_imem_rdata      (imem_rdata),
    .o_dmem_addr       (dmem_addr),
    .o_dmem_wdata      (dmem_wdata),
    .o_dmem_ren        (dmem_ren),
    .o_dmem_wen        (dmem_wen),
    .i_dmem_rdata      (dmem_rdata),
    .o_retire_valid    (retire_valid),
    .o_retire_halt     (retire_halt),
    .o_retire_inst     (retire_inst),
    .o_retire_pc       (retire_pc),
    .o_retire_rd_wdata (retire_rd_wdata),
    .o_retire_rd_waddr (retire_rd_waddr)
  );

  // addresses are taken at the rising edge, read data is driven at the falling edge
  always @(posedge clk) begin
    imem_addr_q <= imem_raddr;
    if (dmem_ren) dmem_addr_q <= dmem_addr;
    if (dmem_wen) dmem[dmem_addr[9:2]] <= dmem_wdata;  // a write lands at this edge
  end

  always @(negedge clk) begin
    imem_rdata <= imem[imem_addr_q[7:2]];
    dmem_rdata <= dmem[dmem_addr_q[9:2]];
  end

  // the program holds exactly one store, so every write strobe must match it
  always @(posedge clk) begin
    if (dmem_wen === 1'b1) begin
      compare("o_dmem_addr", dmem_addr, st_addr);
      compare("o_dmem_wdata", dmem_wdata, st_data);
      stores <= stores + 1;
    end
  end

  always @(negedge clk) begin
    if (rv_core_i.sva_i.fails != 0) stop_run("an assertion in the bound checker failed");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic compare(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t ns: %s is 0x%h, expected 0x%h",
                         $time, name, got, exp));
    end
  endtask

  // with quiet set the data memory strobes must stay low while waiting
  task automatic wait_retire(input bit quiet);
    bit seen;
    seen = 1'b0;
    for (int c = 0; c < 40 && !seen; c++) begin
      @(posedge clk);
      if (quiet) begin
        compare("o_dmem_ren", dmem_ren, 0);
        compare("o_dmem_wen", dmem_wen, 0);
      end
      seen = retire_valid;
    end
    if (!seen) stop_run("timeout: no instruction retired within 40 cycles");
  endtask

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t r_word(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_word(input opcode_e opc, input logic [11:0] imm,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_word(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};  // sw only
  endfunction

  function automatic word_t b_word(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_word(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, op_lui};
  endfunction

  function automatic word_t j_word(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // places one word and, if it retires, its expected rd and value
  task automatic put(input word_t inst, input bit retires, input reg_addr_t rd,
                     input word_t data);
    imem[pc_next[7:2]] = inst;
    if (retires) begin
      exp_pc.push_back(pc_next);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
      if (rd != '0) x[rd] = data;
    end
    pc_next += 4;
  endtask

  initial begin
    logic [19:0] u_imm;
    logic [11:0] i1;
    logic [11:0] i2;
    logic [11:0] i3;
    logic [4:0]  sh;
    imem_rdata  = `RV_NOP;
    dmem_rdata  = '0;
    imem_addr_q = '0;
    dmem_addr_q = '0;
    stores      = 0;
    pc_next     = `RV_RESET_ADDR;
    for (int i = 0; i < 64; i++) imem[i] = `RV_NOP;
    for (int i = 0; i < 256; i++) dmem[i] = word_t'(i) * 32'h0100_0101 ^ 32'hc3c3_0000;
    for (int i = 0; i < 32; i++) x[i] = '0;
    seed  = 32'h3dfa_45df;
    u_imm = 20'($random(seed));
    i1    = 12'($random(seed));
    i2    = 12'($random(seed));
    i3    = 12'($random(seed));
    sh    = 5'($random(seed));

    // dependent ALU chain, each op reads the one or two before it
    put(u_word(u_imm, 1), 1, 1, {u_imm, 12'h000});
    put(i_word(op_imm, i1, 1, 3'b000, 1), 1, 1, x[1] + sext12(i1));
    put(i_word(op_imm, i2, 0, 3'b000, 2), 1, 2, sext12(i2));
    put(r_word(7'h00, 2, 1, 3'b000, 3), 1, 3, x[1] + x[2]);
    put(r_word(7'h20, 1, 3, 3'b000, 4), 1, 4, x[3] - x[1]);
    put(r_word(7'h00, 3, 4, 3'b100, 5), 1, 5, x[4] ^ x[3]);
    put(r_word(7'h00, 2, 5, 3'b111, 6), 1, 6, x[5] & x[2]);
    put(r_word(7'h00, 1, 6, 3'b110, 7), 1, 7, x[6] | x[1]);
    put(r_word(7'h00, 2, 1, 3'b010, 8), 1, 8, ($signed(x[1]) < $signed(x[2])) ? 1 : 0);
    put(r_word(7'h00, 8, 7, 3'b001, 9), 1, 9, x[7] << x[8][4:0]);
    put(r_word(7'h00, 2, 1, 3'b101, 10), 1, 10, x[1] >> x[2][4:0]);
    put(i_word(op_imm, i3, 2, 3'b100, 18), 1, 18, x[2] ^ sext12(i3));
    put(i_word(op_imm, i3, 18, 3'b110, 19), 1, 19, x[18] | sext12(i3));
    put(i_word(op_imm, i3, 19, 3'b111, 20), 1, 20, x[19] & sext12(i3));
    put(i_word(op_imm, i3, 1, 3'b010, 21), 1, 21,
        ($signed(x[1]) < $signed(sext12(i3))) ? 1 : 0);
    put(i_word(op_imm, {7'h00, sh}, 20, 3'b001, 22), 1, 22, x[20] << sh);
    put(i_word(op_imm, {7'h00, sh}, 22, 3'b101, 23), 1, 23, x[22] >> sh);

    // store, reload, then a use right behind the load
    put(i_word(op_imm, 12'h100, 0, 3'b000, 11), 1, 11, 32'h100);
    st_addr = x[11] + 8;
    st_data = x[3];
    put(s_word(12'h008, 3, 11), 1, 0, 0);
    put(i_word(op_load, 12'h008, 11, 3'b010, 12), 1, 12, x[3]);
    put(r_word(7'h00, 2, 12, 3'b000, 13), 1, 13, x[12] + x[2]);

    // control flow, the words marked 0 must never retire
    put(b_word(13'd8, 13, 13, 3'b000), 1, 0, 0);  // beq taken
    put(i_word(op_imm, 12'h001, 0, 3'b000, 14), 0, 14, 1);
    put(b_word(13'd8, 1, 1, 3'b001), 1, 0, 0);  // bne falls through
    put(i_word(op_imm, 12'h005, 0, 3'b000, 15), 1, 15, 5);
    put(j_word(21'd8, 16), 1, 16, pc_next + 4);
    put(i_word(op_imm, 12'h007, 0, 3'b000, 17), 0, 17, 7);
    put(`RV_EBREAK, 1, 0, 0);

    // nothing may retire or touch data memory while reset is held
    @(posedge clk);
    for (int c = 0; c < 40 && rst; c++) begin
      @(posedge clk);
      compare("o_retire_valid", retire_valid, 0);
      compare("o_dmem_ren", dmem_ren, 0);
      compare("o_dmem_wen", dmem_wen, 0);
    end
    if (rst) stop_run("timeout: reset was never released");

    for (int k = 0; k < exp_pc.size(); k++) begin
      wait_retire(k == 0);
      compare("o_retire_pc", retire_pc, exp_pc[k]);
      compare("o_retire_inst", retire_inst, imem[exp_pc[k][7:2]]);
      compare("o_retire_rd_waddr", retire_rd_waddr, exp_rd[k]);
      if (exp_rd[k] != '0) compare("o_retire_rd_wdata", retire_rd_wdata, exp_data[k]);
      compare("o_retire_halt", retire_halt, k == exp_pc.size() - 1);  // only ebreak halts
    end
    compare("store count", stores, 1);

    @(negedge clk);  // the checker has evaluated the last edge by now
    if (rv_core_i.sva_i.fails != 0) begin
      stop_run("an assertion in the bound checker failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- files.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_hazard.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
test/rv_tb_clock.sv
test/rv_core_sva.sv
test/rv_core_tb.sv
